//--- verilog.f
src/decode_pkg.sv
src/imm_gen.sv
src/alu_decode.sv
src/mem_decode.sv
src/branch_decode.sv
src/decode_ctrl.sv
src/decode_stage.sv
testbench/tb_decode_stage.sv

//--- run.sh
#!/bin/sh
cd "$(dirname "$0")" &&
    verilator --binary --timing --assert -Wno-fatal -f verilog.f \
        --top-module tb_decode_stage -o sim_decode_stage &&
    ./obj_dir/sim_decode_stage | tee /dev/stderr | grep -q "Test completed successfully" ||
    { echo "Simulation did not pass"; exit 1; }

//--- testbench/tb_decode_stage.sv
`timescale 1ns/100ps

module tb_decode_stage import decode_pkg::*; ();

    localparam int RANDOM_WORDS = 500;
    // Roughly twice the cycles that all tests need together
    localparam int TIMEOUT_CYCLES = 2000;
    localparam logic [6:0] OPCODE_LIST [0:11] = '{
        OPCODE_LOAD, OPCODE_MISC_MEM, OPCODE_OP_IMM, OPCODE_AUIPC, OPCODE_OP_IMM_32,
        OPCODE_STORE, OPCODE_OP, OPCODE_LUI, OPCODE_OP_32, OPCODE_BRANCH, OPCODE_JALR,
        OPCODE_JAL
    };

    logic           clk = 1'b0;
    logic           reset;
    logic           in_valid;
    instr_word_u    instr;
    logic [63:0]    pc;
    logic           out_valid;
    decoded_instr_t decoded;

    logic [31:0]    rng = 32'd10846;
    logic [63:0]    next_pc = 64'hffff_ffc0_0000_1000;
    logic           exp_pending = 1'b0;
    decoded_instr_t exp_next = '0;
    decoded_instr_t held = '0;
    int             cycles = 0;
    int             errors = 0;
    int             errors_at_start = 0;
    int             tests_passed = 0;
    int             tests_failed = 0;

    decode_stage #(.XLEN(64)) i_dut (
        .clk       (clk),
        .reset     (reset),
        .in_valid  (in_valid),
        .instr     (instr),
        .pc        (pc),
        .out_valid (out_valid),
        .decoded   (decoded)
    );

    always #10 clk = ~clk;

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // Reference decode for RV64I with M classification
    function automatic decoded_instr_t expected_decode(input logic [31:0] w,
                                                       input logic [63:0] p);
        decoded_instr_t d;
        logic [2:0]  f3;
        logic [6:0]  f7;
        logic [6:0]  f7_shift;
        logic [31:0] i_imm;
        logic [31:0] s_imm;
        d = '0;
        f3 = w[14:12];
        f7 = w[31:25];
        i_imm = {{20{w[31]}}, w[31:20]};
        s_imm = {{20{w[31]}}, w[31:25], w[11:7]};
        d.op_type = ALU;
        d.op = ADD;
        d.condition = CC_EQ;
        d.mem_op = MEM_LOAD;
        d.pc = p;
        d.adder_use_imm = !(w[6:0] == OPCODE_OP || w[6:0] == OPCODE_OP_32);
        case (w[6:0])
            OPCODE_LOAD, OPCODE_STORE: begin
                d.op_type = MEM;
                d.use_imm = 1'b1;
                d.mem_size = f3[1:0];
                d.mem_zeroext = f3[2];
                d.rs1 = w[19:15];
                if (w[5]) begin
                    d.mem_op = MEM_STORE;
                    d.immediate = s_imm;
                    d.rs2 = w[24:20];
                    d.illegal = f3[2];
                end else begin
                    d.immediate = i_imm;
                    d.rd = w[11:7];
                    d.illegal = f3 == 3'b111;
                end
            end
            OPCODE_OP, OPCODE_OP_IMM, OPCODE_OP_32, OPCODE_OP_IMM_32: begin
                d.is_32 = w[3];
                d.rs1 = w[19:15];
                d.rd = w[11:7];
                if (w[5]) begin
                    d.rs2 = w[24:20];
                end else begin
                    d.use_imm = 1'b1;
                    d.immediate = i_imm;
                end
                // SLLI, SRLI and SRAI take a six bit shamt
                f7_shift = (w[5] || w[3]) ? f7 : {f7[6:1], 1'b0};
                if (w[5] && f7 == 7'h01) begin
                    d.op_type = f3[2] ? DIV : MUL;
                    d.muldiv_op = f3[1:0];
                    d.illegal = w[3] && !f3[2] && f3 != 3'b000;
                end else begin
                    case (f3)
                        3'b000: begin
                            if (w[5] && f7 == 7'h20) d.op = SUB;
                            d.illegal = w[5] && f7 != 7'h00 && f7 != 7'h20;
                        end
                        3'b001: begin
                            d.op = SHIFT;
                            d.shifter_left = 1'b1;
                            d.illegal = f7_shift != 7'h00;
                        end
                        3'b010, 3'b011: begin
                            d.op = SCC;
                            d.condition = f3[0] ? CC_LTU : CC_LT;
                        end
                        3'b100: d.op = L_XOR;
                        3'b101: begin
                            d.op = SHIFT;
                            d.shifter_arithmetic = f7_shift == 7'h20;
                            d.illegal = f7_shift != 7'h00 && f7_shift != 7'h20;
                        end
                        3'b110: d.op = L_OR;
                        default: d.op = L_AND;
                    endcase
                    if (f3 != 3'b000 && f3 != 3'b001 && f3 != 3'b101) begin
                        d.illegal = (w[5] && f7 != 7'h00) || w[3];
                    end
                end
            end
            OPCODE_BRANCH: begin
                d.op_type = BRANCH;
                d.immediate = {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
                d.use_pc = 1'b1;
                d.rs1 = w[19:15];
                d.rs2 = w[24:20];
                case (f3)
                    3'b000: d.condition = CC_EQ;
                    3'b001: d.condition = CC_NE;
                    3'b100: d.condition = CC_LT;
                    3'b101: d.condition = CC_GE;
                    3'b110: d.condition = CC_LTU;
                    3'b111: d.condition = CC_GEU;
                    default: begin
                        d.condition = CC_TRUE;
                        d.illegal = 1'b1;
                    end
                endcase
            end
            OPCODE_JALR: begin
                d.op_type = BRANCH;
                d.condition = CC_TRUE;
                d.use_imm = 1'b1;
                d.immediate = i_imm;
                d.rs1 = w[19:15];
                d.rd = w[11:7];
                d.illegal = f3 != 3'b000;
            end
            OPCODE_JAL: begin
                d.op_type = BRANCH;
                d.condition = CC_TRUE;
                d.use_pc = 1'b1;
                d.immediate = {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
                d.rd = w[11:7];
            end
            OPCODE_LUI, OPCODE_AUIPC: begin
                d.use_imm = 1'b1;
                d.use_pc = w[6:0] == OPCODE_AUIPC;
                d.immediate = {w[31:12], 12'h000};
                d.rd = w[11:7];
            end
            OPCODE_MISC_MEM: begin
                if (f3 == 3'b001) d.op_type = FENCE_I;
                d.illegal = f3 != 3'b000 && f3 != 3'b001;
            end
            // SYSTEM, AMO and compressed words land here
            default: d.illegal = 1'b1;
        endcase
        return d;
    endfunction

    task automatic compare_field(input string name, input logic [63:0] e,
                                 input logic [63:0] a);
        if (e !== a) begin
            $display("FAILED at %0t: %s expected %h, actual %h", $time, name, e, a);
        end
    endtask

    task automatic report_diff(input decoded_instr_t e, input decoded_instr_t a);
        compare_field("op_type", 64'(e.op_type), 64'(a.op_type));
        compare_field("op", 64'(e.op), 64'(a.op));
        compare_field("condition", 64'(e.condition), 64'(a.condition));
        compare_field("shifter_left", 64'(e.shifter_left), 64'(a.shifter_left));
        compare_field("shifter_arithmetic", 64'(e.shifter_arithmetic),
                      64'(a.shifter_arithmetic));
        compare_field("is_32", 64'(e.is_32), 64'(a.is_32));
        compare_field("muldiv_op", 64'(e.muldiv_op), 64'(a.muldiv_op));
        compare_field("mem_op", 64'(e.mem_op), 64'(a.mem_op));
        compare_field("mem_size", 64'(e.mem_size), 64'(a.mem_size));
        compare_field("mem_zeroext", 64'(e.mem_zeroext), 64'(a.mem_zeroext));
        compare_field("use_pc", 64'(e.use_pc), 64'(a.use_pc));
        compare_field("use_imm", 64'(e.use_imm), 64'(a.use_imm));
        compare_field("adder_use_imm", 64'(e.adder_use_imm), 64'(a.adder_use_imm));
        compare_field("rs1", 64'(e.rs1), 64'(a.rs1));
        compare_field("rs2", 64'(e.rs2), 64'(a.rs2));
        compare_field("rd", 64'(e.rd), 64'(a.rd));
        compare_field("immediate", 64'(e.immediate), 64'(a.immediate));
        compare_field("pc", e.pc, a.pc);
        compare_field("illegal", 64'(e.illegal), 64'(a.illegal));
    endtask

    // Outputs are stable at the falling edge
    always @(negedge clk) begin
        if (!reset) begin
            if (exp_pending) held = exp_next;
            assert (out_valid == exp_pending) else begin
                $display("FAILED at %0t: out_valid expected %b, actual %b",
                         $time, exp_pending, out_valid);
                errors++;
            end
            assert (decoded == held) else begin
                report_diff(held, decoded);
                errors++;
            end
        end
        exp_pending = in_valid && !reset;
        exp_next = expected_decode(instr, pc);
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles == TIMEOUT_CYCLES) begin
            $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("Test failed");
            $finish;
        end
    end

    task automatic send_word(input logic [31:0] word);
        @(posedge clk);
        in_valid <= 1'b1;
        instr <= word;
        pc <= next_pc;
        next_pc = next_pc + 64'd4;
    endtask

    task automatic idle_cycles(input int n);
        repeat (n) begin
            @(posedge clk);
            in_valid <= 1'b0;
        end
    endtask

    task automatic finish_test(input string name);
        idle_cycles(2);
        if (errors == errors_at_start) begin
            tests_passed++;
            $display("PASS  %s", name);
        end else begin
            tests_failed++;
            $display("FAIL  %s with %0d errors", name, errors - errors_at_start);
        end
        errors_at_start = errors;
    endtask

    initial begin
        logic [31:0] w;
        logic [6:0]  f7_list [0:5];
        logic [31:0] imm_words [0:8];
        f7_list = '{7'h00, 7'h01, 7'h20, 7'h21, 7'h40, 7'h02};
        imm_words = '{32'hfff00093, 32'h7ff12083, 32'hfe112e23, 32'hfe000ee3,
                      32'h800000b7, 32'h00001097, 32'hffdff0ef, 32'h002081b3,
                      32'h4020d193};
        reset = 1'b1;
        in_valid = 1'b0;
        instr = '0;
        pc = '0;
        repeat (8) @(posedge clk);
        reset <= 1'b0;
        idle_cycles(3);

        // Back-to-back strobes, then strobes with gaps
        for (int i = 0; i < 4; i++) send_word(32'h00a00513 + 32'(i << 20));
        idle_cycles(1);
        send_word(32'h00b50533);
        idle_cycles(3);
        send_word(32'h40b50533);
        finish_test("reset and timing");

        for (int i = 0; i < 9; i++) send_word(imm_words[i]);
        for (int i = 0; i < 12; i++) begin
            rng = xorshift(rng);
            send_word({rng[31:7], OPCODE_LIST[i]});
        end
        finish_test("immediates");

        foreach (OPCODE_LIST[k]) begin
            if (OPCODE_LIST[k][4] && !OPCODE_LIST[k][2]) begin
                for (int f3 = 0; f3 < 8; f3++) begin
                    for (int j = 0; j < 6; j++) begin
                        rng = xorshift(rng);
                        send_word({f7_list[j], rng[9:0], 3'(f3), rng[14:10], OPCODE_LIST[k]});
                    end
                end
            end
        end
        finish_test("alu and muldiv");

        for (int f3 = 0; f3 < 16; f3++) begin
            rng = xorshift(rng);
            send_word({rng[31:15], 3'(f3), rng[4:0], f3 < 8 ? OPCODE_LOAD : OPCODE_STORE});
        end
        finish_test("loads and stores");

        for (int f3 = 0; f3 < 24; f3++) begin
            rng = xorshift(rng);
            w = {rng[31:15], 3'(f3), rng[4:0], OPCODE_BRANCH};
            if (f3 >= 8) w[6:0] = f3 < 16 ? OPCODE_JALR : OPCODE_MISC_MEM;
            send_word(w);
        end
        send_word({rng[24:0], OPCODE_JAL});
        send_word({rng[31:7], OPCODE_LUI});
        send_word({rng[30:6], OPCODE_AUIPC});
        send_word(32'h00000073);
        send_word(32'h30529073);
        send_word(32'h0020a2af);
        send_word(32'h00004501);
        send_word(32'h00000000);
        finish_test("control flow and others");

        for (int i = 0; i < RANDOM_WORDS; i++) begin
            rng = xorshift(rng);
            w = rng;
            rng = xorshift(rng);
            // Most words get a real opcode so the deeper fields are reached
            if (rng[3:2] != 2'b00) w[6:0] = OPCODE_LIST[int'(rng[19:16]) % 12];
            send_word(w);
            if (rng[5:4] == 2'b00) idle_cycles(1);
        end
        finish_test("random words");

        $display("Tests passed: %0d, tests failed: %0d", tests_passed, tests_failed);
        if (tests_failed == 0 && errors == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

//--- src/decode_stage.sv
`timescale 1ns/100ps

module decode_stage import decode_pkg::*; #(
    parameter int XLEN = 64
) (
    input  logic           clk,
    input  logic           reset,
    input  logic           in_valid,
    input  instr_word_u    instr,
    input  logic [63:0]    pc,
    output logic           out_valid,
    output decoded_instr_t decoded
);

    imm_dec_t    imm_dec;
    alu_dec_t    alu_dec;
    mem_dec_t    mem_dec;
    branch_dec_t br_dec;

    imm_gen i_imm_gen (
        .instr (instr),
        .imm   (imm_dec)
    );

    alu_decode #(.XLEN(XLEN)) i_alu_decode (
        .instr (instr),
        .alu   (alu_dec)
    );

    mem_decode #(.XLEN(XLEN)) i_mem_decode (
        .instr (instr),
        .mem   (mem_dec)
    );

    branch_decode i_branch_decode (
        .instr (instr),
        .br    (br_dec)
    );

    decode_ctrl #(.XLEN(XLEN)) i_decode_ctrl (
        .clk       (clk),
        .reset     (reset),
        .in_valid  (in_valid),
        .instr     (instr),
        .pc        (pc),
        .alu       (alu_dec),
        .mem       (mem_dec),
        .br        (br_dec),
        .imm       (imm_dec),
        .out_valid (out_valid),
        .decoded   (decoded)
    );

endmodule

//--- src/decode_ctrl.sv
`timescale 1ns/100ps

module decode_ctrl import decode_pkg::*; #(
    parameter int XLEN = 64
) (
    input  logic           clk,
    input  logic           reset,
    input  logic           in_valid,
    input  instr_word_u    instr,
    input  logic [63:0]    pc,
    input  alu_dec_t       alu,
    input  mem_dec_t       mem,
    input  branch_dec_t    br,
    input  imm_dec_t       imm,
    output logic           out_valid,
    output decoded_instr_t decoded
);

    localparam logic [63:0] PC_MASK = {64{1'b1}} >> (64 - XLEN);

    decoded_instr_t next;

    always_comb begin
        next = '0;
        next.op_type = ALU;
        next.op = ADD;
        next.condition = CC_EQ;
        next.mem_op = MEM_LOAD;
        next.pc = pc & PC_MASK;
        next.immediate = imm.immediate;
        next.use_imm = imm.use_imm;
        next.adder_use_imm = imm.adder_use_imm;

        // Opcodes whose low two bits are not 11 fall to the default
        case (instr.r.opcode)
            OPCODE_LOAD, OPCODE_STORE: begin
                next.op_type = MEM;
                next.mem_op = mem.op;
                next.mem_size = mem.size;
                next.mem_zeroext = mem.zeroext;
                next.illegal = mem.illegal;
                next.rs1 = instr.r.rs1;
                if (mem.op == MEM_STORE) next.rs2 = instr.r.rs2;
                else next.rd = instr.r.rd;
            end
            OPCODE_OP_IMM, OPCODE_OP_IMM_32, OPCODE_OP, OPCODE_OP_32: begin
                next.op_type = alu.op_type;
                next.op = alu.op;
                next.condition = alu.condition;
                next.shifter_left = alu.shifter_left;
                next.shifter_arithmetic = alu.shifter_arithmetic;
                next.is_32 = alu.is_32;
                next.muldiv_op = alu.muldiv_op;
                next.illegal = alu.illegal;
                next.rs1 = instr.r.rs1;
                next.rd = instr.r.rd;
                if (instr.r.opcode[5]) next.rs2 = instr.r.rs2;
            end
            OPCODE_BRANCH, OPCODE_JALR, OPCODE_JAL: begin
                next.op_type = BRANCH;
                next.condition = br.condition;
                next.use_pc = br.use_pc;
                next.illegal = br.illegal;
                if (instr.r.opcode != OPCODE_JAL) next.rs1 = instr.r.rs1;
                if (instr.r.opcode == OPCODE_BRANCH) next.rs2 = instr.r.rs2;
                else next.rd = instr.r.rd;
            end
            OPCODE_LUI: next.rd = instr.r.rd;
            OPCODE_AUIPC: begin
                next.rd = instr.r.rd;
                next.use_pc = 1'b1;
            end
            // FENCE executes as a no-op
            OPCODE_MISC_MEM: begin
                if (instr.r.funct3 == 3'b001) next.op_type = FENCE_I;
                else if (instr.r.funct3 != 3'b000) next.illegal = 1'b1;
            end
            default: next.illegal = 1'b1;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            out_valid <= 1'b0;
            decoded <= '0;
        end else begin
            out_valid <= in_valid;
            if (in_valid) decoded <= next;
        end
    end

endmodule

//--- src/branch_decode.sv
`timescale 1ns/100ps

module branch_decode import decode_pkg::*; (
    input  instr_word_u instr,
    output branch_dec_t br
);

    logic [2:0] funct3;
    logic       is_jump;
    logic       is_jal;

    assign funct3 = instr.r.funct3;
    // Bit 2 splits jumps from branches, bit 3 splits JAL from JALR
    assign is_jump = instr.r.opcode[2];
    assign is_jal = instr.r.opcode[3];

    always_comb begin
        br.condition = CC_TRUE;
        br.use_pc = !is_jump || is_jal;
        br.illegal = 1'b0;
        if (!is_jump) begin
            case (funct3)
                3'b000: br.condition = CC_EQ;
                3'b001: br.condition = CC_NE;
                3'b100: br.condition = CC_LT;
                3'b101: br.condition = CC_GE;
                3'b110: br.condition = CC_LTU;
                3'b111: br.condition = CC_GEU;
                default: br.illegal = 1'b1;
            endcase
        end else if (!is_jal && funct3 != 3'b000) begin
            br.illegal = 1'b1;
        end
    end

endmodule

//--- src/mem_decode.sv
`timescale 1ns/100ps

module mem_decode import decode_pkg::*; #(
    parameter int XLEN = 64
) (
    input  instr_word_u instr,
    output mem_dec_t    mem
);

    logic [2:0] funct3;
    logic       is_store;
    logic       load_bad;
    logic       store_bad;

    assign funct3 = instr.r.funct3;
    assign is_store = instr.r.opcode[5];

    // LD and LWU exist only on RV64
    always_comb begin
        load_bad = funct3 == 3'b111;
        if (XLEN == 32 && (funct3[1:0] == 2'b11 || funct3 == 3'b110)) begin
            load_bad = 1'b1;
        end
    end

    always_comb begin
        store_bad = funct3[2];
        if (XLEN == 32 && funct3[1:0] == 2'b11) begin
            store_bad = 1'b1;
        end
    end

    always_comb begin
        mem.op = is_store ? MEM_STORE : MEM_LOAD;
        mem.size = funct3[1:0];
        mem.zeroext = funct3[2];
        mem.illegal = is_store ? store_bad : load_bad;
    end

endmodule

//--- src/alu_decode.sv
`timescale 1ns/100ps

module alu_decode import decode_pkg::*; #(
    parameter int XLEN = 64
) (
    input  instr_word_u instr,
    output alu_dec_t    alu
);

    logic [6:0] funct7;
    logic [2:0] funct3;
    logic       is_reg;
    logic       is_word;
    logic       wide_shamt;
    logic [6:0] funct7_chk;

    assign funct7 = instr.r.funct7;
    assign funct3 = instr.r.funct3;
    assign is_reg = instr.r.opcode[5];
    assign is_word = instr.r.opcode[3];

    // RV64 immediate shifts use bit 25 as shamt[5]
    assign wide_shamt = (XLEN == 64) && !is_reg && !is_word;
    assign funct7_chk = {funct7[6:1], funct7[0] & ~wide_shamt};

    always_comb begin
        alu = '0;
        alu.op_type = ALU;
        alu.op = ADD;
        alu.condition = CC_EQ;
        alu.is_32 = is_word;

        if (is_reg && funct7 == 7'b0000001) begin
            alu.muldiv_op = funct3[1:0];
            if (funct3[2]) begin
                alu.op_type = DIV;
            end else begin
                alu.op_type = MUL;
                // MULW is the only word multiply
                if (is_word && funct3 != 3'b000) alu.illegal = 1'b1;
            end
        end else begin
            case (funct3)
                3'b000: begin
                    if (is_reg) begin
                        if (funct7 == 7'b0100000) alu.op = SUB;
                        else if (funct7 != 7'b0) alu.illegal = 1'b1;
                    end
                end
                3'b001: begin
                    alu.op = SHIFT;
                    alu.shifter_left = 1'b1;
                    if (funct7_chk != 7'b0) alu.illegal = 1'b1;
                end
                3'b010, 3'b011: begin
                    alu.op = SCC;
                    alu.condition = funct3[0] ? CC_LTU : CC_LT;
                end
                3'b100: alu.op = L_XOR;
                3'b101: begin
                    alu.op = SHIFT;
                    if (funct7_chk == 7'b0100000) alu.shifter_arithmetic = 1'b1;
                    else if (funct7_chk != 7'b0) alu.illegal = 1'b1;
                end
                3'b110: alu.op = L_OR;
                default: alu.op = L_AND;
            endcase

            if (is_reg && funct3 != 3'b000 && funct3 != 3'b101 && funct7 != 7'b0) begin
                alu.illegal = 1'b1;
            end
            // Word forms only have add, sub and shifts
            if (is_word && funct3 != 3'b000 && funct3 != 3'b001 && funct3 != 3'b101) begin
                alu.illegal = 1'b1;
            end
        end

        if (is_word && XLEN == 32) alu.illegal = 1'b1;
    end

endmodule

//--- src/imm_gen.sv
`timescale 1ns/100ps

module imm_gen import decode_pkg::*; (
    input  instr_word_u instr,
    output imm_dec_t    imm
);

    logic [11:0] i_imm;
    logic [11:0] s_imm;
    logic [12:0] b_imm;
    logic [31:0] u_imm;
    logic [20:0] j_imm;

    assign i_imm = {instr.r.funct7, instr.r.rs2};
    assign s_imm = {instr.sb.imm_hi, instr.sb.imm_lo};
    assign b_imm = {instr.sb.imm_hi[6], instr.sb.imm_lo[0], instr.sb.imm_hi[5:0],
                    instr.sb.imm_lo[4:1], 1'b0};
    assign u_imm = {instr.r.funct7, instr.r.rs2, instr.r.rs1, instr.r.funct3, 12'b0};
    assign j_imm = {instr.r.funct7[6], instr.r.rs1, instr.r.funct3, instr.r.rs2[0],
                    instr.r.funct7[5:0], instr.r.rs2[4:1], 1'b0};

    always_comb begin
        imm.immediate = '0;
        imm.use_imm = 1'b0;
        imm.adder_use_imm = 1'b1;
        case (instr.r.opcode)
            OPCODE_LOAD, OPCODE_OP_IMM, OPCODE_OP_IMM_32, OPCODE_JALR: begin
                imm.use_imm = 1'b1;
                imm.immediate = {{20{i_imm[11]}}, i_imm};
            end
            OPCODE_AUIPC, OPCODE_LUI: begin
                imm.use_imm = 1'b1;
                imm.immediate = u_imm;
            end
            OPCODE_STORE: begin
                imm.use_imm = 1'b1;
                imm.immediate = {{20{s_imm[11]}}, s_imm};
            end
            // Branch target offset goes to the adder only
            OPCODE_BRANCH: imm.immediate = {{19{b_imm[12]}}, b_imm};
            OPCODE_JAL:    imm.immediate = {{11{j_imm[20]}}, j_imm};
            OPCODE_OP, OPCODE_OP_32: imm.adder_use_imm = 1'b0;
            default: ;
        endcase
    end

endmodule

//--- src/decode_pkg.sv
package decode_pkg;

    localparam logic [6:0] OPCODE_LOAD      = 7'b0000011;
    localparam logic [6:0] OPCODE_MISC_MEM  = 7'b0001111;
    localparam logic [6:0] OPCODE_OP_IMM    = 7'b0010011;
    localparam logic [6:0] OPCODE_AUIPC     = 7'b0010111;
    localparam logic [6:0] OPCODE_OP_IMM_32 = 7'b0011011;
    localparam logic [6:0] OPCODE_STORE     = 7'b0100011;
    localparam logic [6:0] OPCODE_OP        = 7'b0110011;
    localparam logic [6:0] OPCODE_LUI       = 7'b0110111;
    localparam logic [6:0] OPCODE_OP_32     = 7'b0111011;
    localparam logic [6:0] OPCODE_BRANCH    = 7'b1100011;
    localparam logic [6:0] OPCODE_JALR      = 7'b1100111;
    localparam logic [6:0] OPCODE_JAL       = 7'b1101111;

    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } instr_r_t;

    // Immediate bits of the S and B formats sit where funct7 and rd are
    typedef struct packed {
        logic [6:0] imm_hi;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] imm_lo;
        logic [6:0] opcode;
    } instr_imm_t;

    typedef union packed {
        instr_r_t   r;
        instr_imm_t sb;
    } instr_word_u;

    typedef enum logic [2:0] {ALU, MEM, BRANCH, MUL, DIV, FENCE_I} op_type_e;

    typedef enum logic [2:0] {ADD, SUB, SCC, L_XOR, L_OR, L_AND, SHIFT} alu_op_e;

    typedef enum logic [2:0] {
        CC_EQ, CC_NE, CC_LT, CC_GE, CC_LTU, CC_GEU, CC_TRUE
    } condition_e;

    typedef enum logic {MEM_LOAD, MEM_STORE} mem_op_e;

    typedef struct packed {
        op_type_e   op_type;
        alu_op_e    op;
        condition_e condition;
        logic       shifter_left;
        logic       shifter_arithmetic;
        logic       is_32;
        // MUL selects the product half, DIV holds {rem, is_unsigned}
        logic [1:0] muldiv_op;
        logic       illegal;
    } alu_dec_t;

    typedef struct packed {
        mem_op_e    op;
        logic [1:0] size;
        logic       zeroext;
        logic       illegal;
    } mem_dec_t;

    typedef struct packed {
        condition_e condition;
        logic       use_pc;
        logic       illegal;
    } branch_dec_t;

    typedef struct packed {
        logic [31:0] immediate;
        logic        use_imm;
        logic        adder_use_imm;
    } imm_dec_t;

    typedef struct packed {
        op_type_e    op_type;
        alu_op_e     op;
        condition_e  condition;
        logic        shifter_left;
        logic        shifter_arithmetic;
        logic        is_32;
        logic [1:0]  muldiv_op;
        mem_op_e     mem_op;
        logic [1:0]  mem_size;
        logic        mem_zeroext;
        logic        use_pc;
        logic        use_imm;
        logic        adder_use_imm;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [4:0]  rd;
        logic [31:0] immediate;
        logic [63:0] pc;
        logic        illegal;
    } decoded_instr_t;

endpackage
